// File: conv_pkg.sv
package conv_pkg;

    // Array geometry
    localparam int MEM_WORDS    = 25;
    localparam int KERNEL_SIZE  = 3;
    localparam int FMAP_SIZE    = 4;
    localparam int NUM_TAPS     = 9;
    localparam int NUM_WIN      = 4;

    // Memory layout: weights column by column, then pixels row by row
    localparam int WEIGHT_BASE  = 0;
    localparam int FEATURE_BASE = 9;

    typedef logic [7:0]  pixel_t;     // Weight or pixel
    typedef logic [4:0]  mem_addr_t;
    typedef logic [19:0] acc_t;       // Nine 8x8 products
    typedef logic [1:0]  win_t;       // 0 c11, 1 c12, 2 c21, 3 c22
    typedef logic [3:0]  tap_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam win_t WIN_LAST = win_t'(NUM_WIN - 1);

    // APB byte addresses
    localparam apb_addr_t ADDR_MEM_LAST = 8'h60;
    localparam apb_addr_t ADDR_CTRL     = 8'h80;  // Bit 0 start
    localparam apb_addr_t ADDR_STATUS   = 8'h84;  // Bit 0 busy, bit 1 done
    localparam apb_addr_t ADDR_RESULT   = 8'h90;  // c11..c22 at 0x90..0x9C

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,
        ST_WAIT,
        ST_STORE,
        ST_DRAIN,
        ST_DONE
    } ctrl_state_t;

endpackage

// File: conv_mem.sv
`timescale 1ns/1ps

module conv_mem (
    input  logic               clk,
    input  logic               we,
    input  conv_pkg::mem_addr_t waddr,
    input  conv_pkg::pixel_t    wdata,
    input  conv_pkg::mem_addr_t raddr,
    output conv_pkg::pixel_t    rdata
);

    conv_pkg::pixel_t mem [conv_pkg::MEM_WORDS];

    // Host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Engine read port, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: conv_host_regs.sv
`timescale 1ns/1ps

module conv_host_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  conv_pkg::apb_addr_t  paddr,
    input  conv_pkg::apb_data_t  pwdata,
    output conv_pkg::apb_data_t  prdata,
    output logic                 pslverr,
    output logic                 mem_we,
    output conv_pkg::mem_addr_t  mem_waddr,
    output conv_pkg::pixel_t     mem_wdata,
    output logic                 start,
    input  logic                 busy,
    input  logic                 finish,
    input  logic                 result_we,
    input  conv_pkg::win_t       result_win,
    input  conv_pkg::acc_t       sum
);

    logic                access;
    logic                setup_rd;
    logic                is_mem;
    logic                is_ctrl;
    logic                is_status;
    logic                is_result;
    logic                mapped;
    logic                wr_ro;
    logic                wr_busy;
    logic                done;
    conv_pkg::win_t      rd_win;
    conv_pkg::apb_data_t rd_mux;
    conv_pkg::acc_t      result [conv_pkg::NUM_WIN];

    assign access   = psel && penable;
    assign setup_rd = psel && !penable && !pwrite;

    // Address decode, word aligned only
    assign is_mem    = (paddr <= conv_pkg::ADDR_MEM_LAST) && (paddr[1:0] == 2'b00);
    assign is_ctrl   = (paddr == conv_pkg::ADDR_CTRL);
    assign is_status = (paddr == conv_pkg::ADDR_STATUS);
    assign is_result = (paddr[7:4] == conv_pkg::ADDR_RESULT[7:4]) && (paddr[1:0] == 2'b00);
    assign mapped    = is_mem || is_ctrl || is_status || is_result;
    assign rd_win    = conv_pkg::win_t'(paddr[3:2]);

    assign wr_ro   = pwrite && (is_status || is_result);
    assign wr_busy = pwrite && (is_mem || is_ctrl) && busy;

    assign pslverr = access && (!mapped || wr_ro || wr_busy);

    // Memory word writes, rejected while a run is in progress
    assign mem_we    = access && pwrite && is_mem && !busy;
    assign mem_waddr = conv_pkg::mem_addr_t'(paddr[6:2]);
    assign mem_wdata = pwdata[7:0];

    assign start = access && pwrite && is_ctrl && !busy && pwdata[0];

    // Sticky done, cleared by the next accepted start
    always_ff @(posedge clk) begin
        if (!rst) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (finish) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < conv_pkg::NUM_WIN; i++) begin
                result[i] <= '0;
            end
        end else if (result_we) begin
            result[result_win] <= sum;
        end
    end

    always_comb begin
        rd_mux = '0;                    // Memory, control and unmapped read as zero
        if (is_status) begin
            rd_mux = {30'b0, done, busy};
        end else if (is_result) begin
            rd_mux = conv_pkg::apb_data_t'(result[rd_win]);
        end
    end

    // Read data is captured in the setup cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            prdata <= '0;
        end else if (setup_rd) begin
            prdata <= rd_mux;
        end
    end

endmodule

// File: conv_controller.sv
`timescale 1ns/1ps

module conv_controller (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    output logic           busy,
    output logic           mac_start,
    output conv_pkg::win_t win,
    input  logic           mac_done,
    output logic           result_we,
    output conv_pkg::win_t result_win,
    output logic           finish
);

    conv_pkg::ctrl_state_t state;
    conv_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= conv_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Window index walks c11, c12, c21, c22
    always_ff @(posedge clk) begin
        if (!rst) begin
            win <= '0;
        end else if (state == conv_pkg::ST_STORE) begin
            win <= win + 1'b1;          // Wraps to c11 after the last window
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            conv_pkg::ST_IDLE: begin
                if (start) begin
                    next_state = conv_pkg::ST_RUN;
                end
            end
            conv_pkg::ST_RUN: begin
                next_state = conv_pkg::ST_WAIT;
            end
            conv_pkg::ST_WAIT: begin
                if (mac_done) begin
                    next_state = conv_pkg::ST_STORE;
                end
            end
            conv_pkg::ST_STORE: begin
                if (win == conv_pkg::WIN_LAST) begin
                    next_state = conv_pkg::ST_DRAIN;
                end else begin
                    next_state = conv_pkg::ST_RUN;
                end
            end
            conv_pkg::ST_DRAIN: begin
                next_state = conv_pkg::ST_DONE;
            end
            conv_pkg::ST_DONE: begin
                next_state = conv_pkg::ST_IDLE;
            end
            default: begin
                next_state = conv_pkg::ST_IDLE;
            end
        endcase
    end

    assign busy       = (state != conv_pkg::ST_IDLE);
    assign mac_start  = (state == conv_pkg::ST_RUN);
    assign result_we  = (state == conv_pkg::ST_STORE);    // Engine sum still holds here
    assign result_win = win;
    assign finish     = (state == conv_pkg::ST_DONE);

endmodule

// File: conv_mac_engine.sv
`timescale 1ns/1ps

module conv_mac_engine (
    input  logic                clk,
    input  logic                rst,
    input  logic                mac_start,
    input  conv_pkg::win_t      win,
    output conv_pkg::mem_addr_t rd_addr,
    input  conv_pkg::pixel_t    rd_data,
    output logic                mac_done,
    output conv_pkg::acc_t      sum
);

    localparam conv_pkg::tap_t LAST_TAP = conv_pkg::tap_t'(conv_pkg::NUM_TAPS - 1);

    logic                rd_active;
    logic                phase;         // 0 weight read, 1 pixel read
    conv_pkg::tap_t      tap;
    logic                wgt_vld;
    logic                pix_vld;
    logic                last_vld;
    conv_pkg::mem_addr_t base;
    conv_pkg::pixel_t    wgt_q;
    conv_pkg::acc_t      acc;
    conv_pkg::acc_t      prod;
    logic [1:0]          row;
    logic [1:0]          col;
    conv_pkg::mem_addr_t pix_addr;
    conv_pkg::mem_addr_t wgt_addr;

    assign row = 2'(tap / conv_pkg::KERNEL_SIZE);
    assign col = 2'(tap % conv_pkg::KERNEL_SIZE);

    assign pix_addr = conv_pkg::mem_addr_t'(base + row * conv_pkg::FMAP_SIZE + col);
    assign wgt_addr = conv_pkg::mem_addr_t'(conv_pkg::WEIGHT_BASE
                                            + col * conv_pkg::KERNEL_SIZE + row);
    assign rd_addr  = phase ? pix_addr : wgt_addr;

    // Read sequencer and data valid pipeline
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_active <= 1'b0;
            phase     <= 1'b0;
            tap       <= '0;
            wgt_vld   <= 1'b0;
            pix_vld   <= 1'b0;
            last_vld  <= 1'b0;
            mac_done  <= 1'b0;
        end else begin
            wgt_vld  <= rd_active && !phase;
            pix_vld  <= rd_active && phase;
            last_vld <= rd_active && phase && (tap == LAST_TAP);
            mac_done <= last_vld;       // Sum final after the last pixel
            if (mac_start) begin
                rd_active <= 1'b1;
                phase     <= 1'b0;
                tap       <= '0;
            end else if (rd_active) begin
                phase <= !phase;
                if (phase) begin
                    if (tap == LAST_TAP) begin
                        rd_active <= 1'b0;
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
            end
        end
    end

    assign prod = conv_pkg::acc_t'(wgt_q) * conv_pkg::acc_t'(rd_data);

    always_ff @(posedge clk) begin
        if (mac_start) begin
            base <= conv_pkg::mem_addr_t'(conv_pkg::FEATURE_BASE
                                          + conv_pkg::FMAP_SIZE * win[1] + win[0]);
            acc  <= '0;
        end else if (pix_vld) begin
            acc <= acc + prod;
        end
        if (wgt_vld) begin
            wgt_q <= rd_data;           // Held until its pixel arrives
        end
    end

    assign sum = acc;

endmodule

// File: conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  conv_pkg::apb_addr_t paddr,
    input  conv_pkg::apb_data_t pwdata,
    output conv_pkg::apb_data_t prdata,
    output logic                pslverr
);

    logic                mem_we;
    conv_pkg::mem_addr_t mem_waddr;
    conv_pkg::pixel_t    mem_wdata;
    conv_pkg::mem_addr_t rd_addr;
    conv_pkg::pixel_t    rd_data;
    logic                start;
    logic                busy;
    logic                finish;
    logic                mac_start;
    logic                mac_done;
    conv_pkg::win_t      win;
    logic                result_we;
    conv_pkg::win_t      result_win;
    conv_pkg::acc_t      sum;

    conv_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    conv_host_regs u_host_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .start      (start),
        .busy       (busy),
        .finish     (finish),
        .result_we  (result_we),
        .result_win (result_win),
        .sum        (sum)
    );

    conv_controller u_controller (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .mac_start  (mac_start),
        .win        (win),
        .mac_done   (mac_done),
        .result_we  (result_we),
        .result_win (result_win),
        .finish     (finish)
    );

    conv_mac_engine u_mac_engine (
        .clk       (clk),
        .rst       (rst),
        .mac_start (mac_start),
        .win       (win),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .mac_done  (mac_done),
        .sum       (sum)
    );

endmodule

// File: conv_asserts.sv
`timescale 1ns/1ps

module conv_asserts (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic mem_we,
    input logic start,
    input logic busy,
    input logic result_we,
    input logic mac_start,
    input logic mac_done
);

    logic in_window;    // Engine between mac_start and mac_done

    always_ff @(posedge clk) begin
        if (!rst) begin
            in_window <= 1'b0;
        end else if (mac_start) begin
            in_window <= 1'b1;
        end else if (mac_done) begin
            in_window <= 1'b0;
        end
    end

    // An error response has no side effect
    a_pslverr_access: assert property (@(posedge clk) disable iff (!rst)
        pslverr |-> (psel && penable && !mem_we && !start))
        else $error("pslverr outside an access phase or with a write taking effect");

    a_result_we_busy: assert property (@(posedge clk) disable iff (!rst)
        result_we |-> (busy && $past(mac_done)))
        else $error("result_we while idle or not one cycle after mac_done");

    a_mac_start_idle: assert property (@(posedge clk) disable iff (!rst)
        mac_start |-> !in_window)
        else $error("mac_start while the engine is mid-window");

endmodule

bind conv_top conv_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pslverr   (pslverr),
    .mem_we    (mem_we),
    .start     (start),
    .busy      (busy),
    .result_we (result_we),
    .mac_start (mac_start),
    .mac_done  (mac_done)
);

// File: tb_conv.sv
`timescale 1ns/1ps

module tb_conv;

    localparam int RUN_CYCLES     = 4 * 23 + 3;      // Four windows, drain and done
    localparam int XFER_CYCLES    = 3;               // Setup, access, idle
    localparam int XFERS_PER_RUN  = conv_pkg::MEM_WORDS + 8;
    localparam int NUM_RUNS       = 10;
    localparam int TIMEOUT_CYCLES = 10 * NUM_RUNS * (RUN_CYCLES + XFERS_PER_RUN * XFER_CYCLES);

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    conv_pkg::apb_addr_t paddr;
    conv_pkg::apb_data_t pwdata;
    conv_pkg::apb_data_t prdata;
    logic                pslverr;

    conv_pkg::pixel_t    mem_model [conv_pkg::MEM_WORDS];
    conv_pkg::acc_t      expected [conv_pkg::NUM_WIN];
    integer              seed;
    int                  cycles = 0;

    conv_top DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // Expected window sum from the memory image
    function automatic conv_pkg::acc_t window_sum(input int w);
        conv_pkg::acc_t total;
        int             r;
        int             c;
        int             pix;
        int             wgt;
        total = '0;
        for (r = 0; r < conv_pkg::KERNEL_SIZE; r++) begin
            for (c = 0; c < conv_pkg::KERNEL_SIZE; c++) begin
                pix = conv_pkg::FEATURE_BASE + (w / 2 + r) * conv_pkg::FMAP_SIZE + w % 2 + c;
                wgt = conv_pkg::WEIGHT_BASE + c * conv_pkg::KERNEL_SIZE + r;   // Column major
                total = total + conv_pkg::acc_t'(mem_model[wgt])
                              * conv_pkg::acc_t'(mem_model[pix]);
            end
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // One APB transfer sampled mid access phase
    task automatic apb_xfer(input logic write, input conv_pkg::apb_addr_t addr,
                            input conv_pkg::apb_data_t wdata,
                            output conv_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_expect(input string name, input conv_pkg::apb_addr_t addr,
                                input conv_pkg::apb_data_t data, input logic exp_err);
        conv_pkg::apb_data_t rdata;
        logic                err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic read_expect(input string name, input conv_pkg::apb_addr_t addr,
                               input conv_pkg::apb_data_t exp_data, input logic exp_err);
        conv_pkg::apb_data_t rdata;
        logic                err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value({name, " pslverr"}, 32'(exp_err), 32'(err));
        check_value({name, " data"}, exp_data, rdata);
    endtask

    task automatic load_memory(input string name);
        int i;
        for (i = 0; i < conv_pkg::MEM_WORDS; i++) begin
            write_expect({name, " load"}, conv_pkg::apb_addr_t'(4 * i), 32'(mem_model[i]), 1'b0);
        end
        for (i = 0; i < conv_pkg::NUM_WIN; i++) begin
            expected[i] = window_sum(i);
        end
    endtask

    task automatic wait_done(input string name);
        conv_pkg::apb_data_t st;
        logic                err;
        st = '0;
        while (!st[1]) begin                            // Poll until done
            apb_xfer(1'b0, conv_pkg::ADDR_STATUS, '0, st, err);
            check_value({name, " poll pslverr"}, 32'd0, 32'(err));
        end
        check_value({name, " final status"}, 32'h2, st);
    endtask

    task automatic check_results(input string name);
        int w;
        for (w = 0; w < conv_pkg::NUM_WIN; w++) begin
            read_expect($sformatf("%s result %0d", name, w),
                        conv_pkg::apb_addr_t'(conv_pkg::ADDR_RESULT + 4 * w),
                        32'(expected[w]), 1'b0);
        end
    endtask

    task automatic run_and_compare(input string name);
        load_memory(name);
        write_expect({name, " start"}, conv_pkg::ADDR_CTRL, 32'h1, 1'b0);
        wait_done(name);
        check_results(name);
    endtask

    initial begin
        int i;
        int n;
        rst     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hee99_d8de;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        read_expect("reset status", conv_pkg::ADDR_STATUS, 32'h0, 1'b0);
        for (i = 0; i < conv_pkg::NUM_WIN; i++) begin
            expected[i] = '0;
        end
        check_results("reset");

        for (i = 0; i < conv_pkg::MEM_WORDS; i++) begin
            mem_model[i] = 8'd1;
        end
        run_and_compare("all ones");
        for (i = 0; i < conv_pkg::NUM_WIN; i++) begin
            read_expect($sformatf("all ones result %0d", i),
                        conv_pkg::apb_addr_t'(conv_pkg::ADDR_RESULT + 4 * i), 32'd9, 1'b0);
        end

        for (i = 0; i < conv_pkg::MEM_WORDS; i++) begin
            mem_model[i] = 8'hff;                       // Widest possible sum
        end
        run_and_compare("all max");

        for (i = 0; i < conv_pkg::MEM_WORDS; i++) begin
            mem_model[i] = conv_pkg::pixel_t'(i * 7 + 3);
        end
        run_and_compare("ramp");

        for (n = 0; n < 6; n++) begin
            for (i = 0; i < conv_pkg::MEM_WORDS; i++) begin
                mem_model[i] = conv_pkg::pixel_t'($random(seed));
            end
            run_and_compare($sformatf("random run %0d", n));
        end

        // Writes rejected and done cleared while busy
        read_expect("done held", conv_pkg::ADDR_STATUS, 32'h2, 1'b0);
        write_expect("restart", conv_pkg::ADDR_CTRL, 32'h1, 1'b0);
        read_expect("busy after start", conv_pkg::ADDR_STATUS, 32'h1, 1'b0);
        write_expect("weight write busy", 8'h00, 32'(~mem_model[0]), 1'b1);
        write_expect("pixel write busy", conv_pkg::ADDR_MEM_LAST, 32'(~mem_model[24]), 1'b1);
        write_expect("start while busy", conv_pkg::ADDR_CTRL, 32'h1, 1'b1);
        wait_done("restart");
        check_results("restart");

        read_expect("unmapped read", 8'h64, 32'h0, 1'b1);
        read_expect("unmapped high read", 8'hA0, 32'h0, 1'b1);
        read_expect("misaligned read", 8'h02, 32'h0, 1'b1);
        write_expect("unmapped write", 8'h64, 32'h1, 1'b1);
        write_expect("status write", conv_pkg::ADDR_STATUS, 32'h0, 1'b1);
        write_expect("result write", 8'h94, 32'h12345, 1'b1);
        read_expect("memory read", 8'h10, 32'h0, 1'b0);
        read_expect("control read", conv_pkg::ADDR_CTRL, 32'h0, 1'b0);
        read_expect("status after errors", conv_pkg::ADDR_STATUS, 32'h2, 1'b0);
        check_results("after errors");

        $display("all tests passed");
        $finish;
    end

endmodule

// File: vlog.f
conv_pkg.sv
conv_mem.sv
conv_host_regs.sv
conv_controller.sv
conv_mac_engine.sv
conv_top.sv
conv_asserts.sv
tb_conv.sv

// File: run.sh
#!/bin/sh
# Build and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_conv -f vlog.f -o sim_conv \
    && ./obj_dir/sim_conv | tee sim.log

grep -q "^all tests passed$" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
